// File: list.f
verilog/intra_pkg.sv
verilog/line_ram.sv
verilog/neighbor_store.sv
verilog/dc_predictor.sv
verilog/intra_neighbor_top.sv
verif/tb_clk_gen.sv
verif/intra_neighbor_props.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_top
FILELIST = list.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove build output and logs"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_top.sv
/*
 * Testbench for intra_neighbor_top: a 5x3 macroblock picture in raster
 * order, then back-to-back requests. Expected values come from a model.
 */
`timescale 1ns/1ps

module tb_top;

    localparam int MB_COLS  = 5;
    localparam int MB_ROWS  = 3;
    localparam int N_REQ    = MB_COLS * MB_ROWS + 2 * MB_COLS;
    localparam int WD_LIMIT = N_REQ * 10 + 100;

    logic                        clk;
    logic                        rst_n;
    logic                        blk_valid;
    logic [intra_pkg::POS_W-1:0] blk_x;
    logic [intra_pkg::BLK_W-1:0] blk_pixels;
    logic                        pred_req;
    logic [intra_pkg::POS_W-1:0] req_x;
    logic [intra_pkg::POS_W-1:0] req_y;
    logic                        nb_valid;
    logic [intra_pkg::ROW_W-1:0] top_row;
    logic                        top_avail;
    logic [intra_pkg::ROW_W-1:0] left_col;
    logic                        left_avail;
    logic                        dc_valid;
    logic [intra_pkg::PIX_W-1:0] dc_value;
    logic [intra_pkg::ROW_W-1:0] exp_top;
    logic [intra_pkg::ROW_W-1:0] exp_left;
    logic                        exp_ta;
    logic                        exp_la;
    logic [intra_pkg::PIX_W-1:0] exp_dc;
    int                          err_count;
    int                          tests_done;
    int                          tests_failed;

    // Model copy of the bottom rows and the last right column
    logic [intra_pkg::ROW_W-1:0] ref_bottom [MB_COLS];
    logic [intra_pkg::ROW_W-1:0] ref_right;
    logic [31:0]                 rng;

    tb_clk_gen u_clk (.clk(clk));

    intra_neighbor_top #(.MAX_MB_COLS(8)) dut (.*);

    tb_checker u_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Rounded DC over whichever neighbours exist
    function automatic logic [7:0] ref_dc(input logic [127:0] top, input logic [127:0] left,
                                         input logic ta, input logic la);
        int st;
        int sl;
        st = 0;
        sl = 0;
        for (int i = 0; i < 16; i++) begin
            st += int'(top[i*8 +: 8]);
            sl += int'(left[i*8 +: 8]);
        end
        if (ta && la) return 8'((st + sl + 16) >> 5);
        if (ta) return 8'((st + 8) >> 4);
        if (la) return 8'((sl + 8) >> 4);
        return 8'd128;
    endfunction

    task automatic drive_request(input int x, input int y);
        @(negedge clk);
        pred_req = 1'b1;
        req_x    = 8'(x);
        req_y    = 8'(y);
        exp_ta   = (y != 0);
        exp_la   = (x != 0);
        exp_top  = ref_bottom[x];
        exp_left = ref_right;
        exp_dc   = ref_dc(exp_top, exp_left, exp_ta, exp_la);
    endtask

    // Called on a falling edge; the strobe lasts one cycle
    task automatic write_block(input int x);
        logic [127:0] row;
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            blk_pixels[i*32 +: 32] = rng;
        end
        blk_valid = 1'b1;
        blk_x     = 8'(x);
        ref_bottom[x] = blk_pixels[127:0];
        // Row r counted from the top, its last sample into byte r from the top
        for (int r = 0; r < 16; r++) begin
            row = blk_pixels[2047 - r*128 -: 128];
            ref_right[127 - r*8 -: 8] = row[7:0];
        end
        @(negedge clk);
        blk_valid = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        blk_valid  = 1'b0;
        blk_x      = '0;
        blk_pixels = '0;
        pred_req   = 1'b0;
        req_x      = '0;
        req_y      = '0;
        exp_top    = '0;
        exp_left   = '0;
        exp_ta     = 1'b0;
        exp_la     = 1'b0;
        exp_dc     = '0;
        rng = 32'd97;
        ref_right = '0;
        foreach (ref_bottom[i]) ref_bottom[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int y = 0; y < MB_ROWS; y++) begin
            for (int x = 0; x < MB_COLS; x++) begin
                drive_request(x, y);
                @(negedge clk);
                pred_req = 1'b0;
                while (!dc_valid) @(negedge clk);
                write_block(x);
            end
        end
        // Back-to-back requests with no writes in between
        for (int y = 0; y < 2; y++) begin
            for (int x = 0; x < MB_COLS; x++) begin
                drive_request(x, y);
            end
        end
        @(negedge clk);
        pred_req = 1'b0;
        wait (tests_done == N_REQ);
        repeat (3) @(negedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WD_LIMIT) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d of %0d tests done",
                 WD_LIMIT, tests_done, N_REQ);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verif/tb_checker.sv
/*
 * Scoreboard for the intra neighbour path. Expected values arrive with each
 * request and are compared at nb_valid and dc_valid, in request order.
 */
`timescale 1ns/1ps

module tb_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pred_req,
    input  logic [intra_pkg::POS_W-1:0] req_x,
    input  logic [intra_pkg::POS_W-1:0] req_y,
    input  logic [intra_pkg::ROW_W-1:0] exp_top,
    input  logic [intra_pkg::ROW_W-1:0] exp_left,
    input  logic                        exp_ta,
    input  logic                        exp_la,
    input  logic [intra_pkg::PIX_W-1:0] exp_dc,
    input  logic                        nb_valid,
    input  logic [intra_pkg::ROW_W-1:0] top_row,
    input  logic                        top_avail,
    input  logic [intra_pkg::ROW_W-1:0] left_col,
    input  logic                        left_avail,
    input  logic                        dc_valid,
    input  logic [intra_pkg::PIX_W-1:0] dc_value,
    output int                          err_count,
    output int                          tests_done,
    output int                          tests_failed
);

    localparam int ROW_W = intra_pkg::ROW_W;

    logic                        req_d1;
    logic                        req_d2;
    logic [intra_pkg::ROW_W-1:0] q_top [$];
    logic [intra_pkg::ROW_W-1:0] q_left [$];
    logic                        q_ta [$];
    logic                        q_la [$];
    logic [intra_pkg::PIX_W-1:0] q_dc [$];
    int                          q_nb_id [$];
    int                          q_dc_id [$];
    int                          test_err [64];
    int                          tx [64];
    int                          ty [64];
    int                          next_id;

    initial begin
        err_count    = 0;
        tests_done   = 0;
        tests_failed = 0;
        next_id      = 0;
        foreach (test_err[i]) test_err[i] = 0;
    end

    task automatic report_value(input string name, input logic [intra_pkg::ROW_W-1:0] exp_v,
                                input logic [intra_pkg::ROW_W-1:0] act_v, input int id);
        if (exp_v !== act_v) begin
            $display("[ERROR] test %0d %s expected 0x%h actual 0x%h", id, name, exp_v, act_v);
            err_count++;
            test_err[id]++;
        end
    endtask

    // Rising-edge compare against falling-edge stimulus
    always @(posedge clk) begin : compare_proc
        int id;
        if (!rst_n) begin
            req_d1 <= 1'b0;
            req_d2 <= 1'b0;
        end else begin
            req_d1 <= pred_req;
            req_d2 <= req_d1;
            if (nb_valid !== req_d1) begin
                $display("nb_valid did not follow pred_req by one cycle at %0t", $time);
                err_count++;
            end
            if (dc_valid !== req_d2) begin
                $display("dc_valid did not follow pred_req by two cycles at %0t", $time);
                err_count++;
            end
            if (nb_valid && q_nb_id.size() > 0) begin
                id = q_nb_id.pop_front();
                report_value("top_avail", ROW_W'(q_ta[0]), ROW_W'(top_avail), id);
                report_value("left_avail", ROW_W'(q_la[0]), ROW_W'(left_avail), id);
                // Samples only matter where the neighbour exists
                if (q_ta[0]) report_value("top_row", q_top[0], top_row, id);
                if (q_la[0]) report_value("left_col", q_left[0], left_col, id);
                void'(q_ta.pop_front());
                void'(q_la.pop_front());
                void'(q_top.pop_front());
                void'(q_left.pop_front());
            end
            if (dc_valid && q_dc_id.size() > 0) begin
                id = q_dc_id.pop_front();
                report_value("dc_value", ROW_W'(q_dc.pop_front()), ROW_W'(dc_value), id);
                if (test_err[id] != 0) tests_failed++;
                tests_done++;
                $display("test %0d mb(%0d,%0d) %s", id, tx[id], ty[id],
                         (test_err[id] == 0) ? "ok" : "mismatch");
            end
            if (pred_req) begin
                tx[next_id] = int'(req_x);
                ty[next_id] = int'(req_y);
                q_top.push_back(exp_top);
                q_left.push_back(exp_left);
                q_ta.push_back(exp_ta);
                q_la.push_back(exp_la);
                q_dc.push_back(exp_dc);
                q_nb_id.push_back(next_id);
                q_dc_id.push_back(next_id);
                next_id++;
            end
        end
    end

endmodule

// File: verif/intra_neighbor_props.sv
/*
 * Strobe and latency properties of the neighbour store.
 * Attached to every neighbor_store instance through bind.
 */
`timescale 1ns/1ps

module intra_neighbor_props (
    input logic clk,
    input logic rst_n,
    input logic blk_valid,
    input logic pred_req,
    input logic nb_valid
);

    // Block write and request never share a cycle
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(blk_valid && pred_req))
        else $error("blk_valid and pred_req high together");

    a_nb_latency: assert property (@(posedge clk) disable iff (!rst_n)
        nb_valid == $past(pred_req))
        else $error("nb_valid not one cycle after pred_req");

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !nb_valid)
        else $error("nb_valid high during reset");

endmodule

bind neighbor_store intra_neighbor_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .blk_valid (blk_valid),
    .pred_req  (pred_req),
    .nb_valid  (nb_valid)
);

// File: verif/tb_clk_gen.sv
/*
 * Free-running testbench clock, 40 ns period.
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial clk = 1'b0;
    always #20 clk = ~clk;

endmodule

// File: verilog/intra_neighbor_top.sv
/*
 * Top level of the intra neighbour path: neighbour store followed by the
 * DC predictor. A request gives neighbours after 1 cycle and DC after 2.
 */
`timescale 1ns/1ps

module intra_neighbor_top #(
    parameter int MAX_MB_COLS = 120
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        blk_valid,
    input  logic [intra_pkg::POS_W-1:0] blk_x,
    input  logic [intra_pkg::BLK_W-1:0] blk_pixels,
    input  logic                        pred_req,
    input  logic [intra_pkg::POS_W-1:0] req_x,
    input  logic [intra_pkg::POS_W-1:0] req_y,
    output logic                        nb_valid,
    output logic [intra_pkg::ROW_W-1:0] top_row,
    output logic                        top_avail,
    output logic [intra_pkg::ROW_W-1:0] left_col,
    output logic                        left_avail,
    output logic                        dc_valid,
    output logic [intra_pkg::PIX_W-1:0] dc_value
);

    neighbor_store #(
        .MAX_MB_COLS (MAX_MB_COLS)
    ) u_neighbor_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .blk_valid  (blk_valid),
        .blk_x      (blk_x),
        .blk_pixels (blk_pixels),
        .pred_req   (pred_req),
        .req_x      (req_x),
        .req_y      (req_y),
        .nb_valid   (nb_valid),
        .top_row    (top_row),
        .top_avail  (top_avail),
        .left_col   (left_col),
        .left_avail (left_avail)
    );

    // Predictor sees the same neighbour bus as the outside
    dc_predictor u_dc_predictor (
        .clk        (clk),
        .rst_n      (rst_n),
        .nb_valid   (nb_valid),
        .top_row    (top_row),
        .top_avail  (top_avail),
        .left_col   (left_col),
        .left_avail (left_avail),
        .dc_valid   (dc_valid),
        .dc_value   (dc_value)
    );

endmodule

// File: verilog/dc_predictor.sv
/*
 * DC intra predictor for 16x16 luma.
 * Sums the available top and left neighbours and registers the rounded mean
 * one cycle after nb_valid.
 */
`timescale 1ns/1ps

module dc_predictor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        nb_valid,
    input  logic [intra_pkg::ROW_W-1:0] top_row,
    input  logic                        top_avail,
    input  logic [intra_pkg::ROW_W-1:0] left_col,
    input  logic                        left_avail,
    output logic                        dc_valid,
    output logic [intra_pkg::PIX_W-1:0] dc_value
);

    localparam int LOG2_MB = $clog2(intra_pkg::MB_SIZE);
    localparam int SUM_W   = intra_pkg::PIX_W + LOG2_MB;
    localparam int TOT_W   = SUM_W + 1;

    logic [SUM_W-1:0]            top_sum;
    logic [SUM_W-1:0]            left_sum;
    logic [TOT_W-1:0]            both_round;
    logic [SUM_W-1:0]            top_round;
    logic [SUM_W-1:0]            left_round;
    logic [intra_pkg::PIX_W-1:0] dc_next;

    // ----------------------------------------
    // Neighbour sums
    // ----------------------------------------
    always_comb begin
        top_sum  = '0;
        left_sum = '0;
        for (int i = 0; i < intra_pkg::MB_SIZE; i++) begin
            top_sum  = top_sum + SUM_W'(top_row[i*intra_pkg::PIX_W +: intra_pkg::PIX_W]);
            left_sum = left_sum + SUM_W'(left_col[i*intra_pkg::PIX_W +: intra_pkg::PIX_W]);
        end
    end

    // Round to nearest over 32 or 16 samples
    assign both_round = (TOT_W'(top_sum) + TOT_W'(left_sum) + TOT_W'(intra_pkg::MB_SIZE))
                        >> (LOG2_MB + 1);
    assign top_round  = (top_sum + SUM_W'(intra_pkg::MB_SIZE / 2)) >> LOG2_MB;
    assign left_round = (left_sum + SUM_W'(intra_pkg::MB_SIZE / 2)) >> LOG2_MB;

    always_comb begin
        case ({top_avail, left_avail})
            2'b11:   dc_next = both_round[intra_pkg::PIX_W-1:0];
            2'b10:   dc_next = top_round[intra_pkg::PIX_W-1:0];
            2'b01:   dc_next = left_round[intra_pkg::PIX_W-1:0];
            default: dc_next = intra_pkg::DC_DEFAULT;
        endcase
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dc_valid <= 1'b0;
        end else begin
            dc_valid <= nb_valid;
        end
    end

    // Value holds until the next valid neighbour set
    always_ff @(posedge clk) begin
        if (nb_valid) begin
            dc_value <= dc_next;
        end
    end

endmodule

// File: verilog/neighbor_store.sv
/*
 * Neighbour sample store for 16x16 luma intra prediction in raster order.
 * Keeps the bottom row of every column in a line RAM and the right column
 * of the last block in a register, and returns both on a request.
 */
`timescale 1ns/1ps

module neighbor_store #(
    parameter int MAX_MB_COLS = 120
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Reconstructed block
    input  logic                        blk_valid,
    input  logic [intra_pkg::POS_W-1:0] blk_x,
    input  logic [intra_pkg::BLK_W-1:0] blk_pixels,

    // Prediction request
    input  logic                        pred_req,
    input  logic [intra_pkg::POS_W-1:0] req_x,
    input  logic [intra_pkg::POS_W-1:0] req_y,

    // Neighbours, valid one cycle after the request
    output logic                        nb_valid,
    output logic [intra_pkg::ROW_W-1:0] top_row,
    output logic                        top_avail,
    output logic [intra_pkg::ROW_W-1:0] left_col,
    output logic                        left_avail
);

    localparam int ADDR_W = (MAX_MB_COLS > 1) ? $clog2(MAX_MB_COLS) : 1;

    logic [intra_pkg::ROW_W-1:0] bottom_row;
    logic [intra_pkg::ROW_W-1:0] right_col;
    logic [intra_pkg::ROW_W-1:0] left_reg;
    logic [ADDR_W-1:0]           wr_addr;
    logic [ADDR_W-1:0]           rd_addr;

    // ----------------------------------------
    // Block edge extraction
    // ----------------------------------------

    // Row 15 is the least significant row of the block
    assign bottom_row = blk_pixels[intra_pkg::ROW_W-1:0];

    // Column 15 is the last byte of each row; row 0 lands in the top byte
    for (genvar r = 0; r < intra_pkg::MB_SIZE; r++) begin : g_right_col
        localparam int SRC_LSB = (intra_pkg::MB_SIZE - 1 - r) * intra_pkg::ROW_W;
        localparam int DST_LSB = (intra_pkg::MB_SIZE - 1 - r) * intra_pkg::PIX_W;

        assign right_col[DST_LSB +: intra_pkg::PIX_W] =
            blk_pixels[SRC_LSB +: intra_pkg::PIX_W];
    end

    // ----------------------------------------
    // Top neighbours in the line RAM
    // ----------------------------------------

    // Only the low bits of the column index reach the RAM
    assign wr_addr = blk_x[ADDR_W-1:0];
    assign rd_addr = req_x[ADDR_W-1:0];

    // Read data stays put until the next request, which is what top_row needs
    line_ram #(
        .DEPTH (MAX_MB_COLS)
    ) u_line_ram (
        .clk   (clk),
        .we    (blk_valid),
        .waddr (wr_addr),
        .wdata (bottom_row),
        .re    (pred_req),
        .raddr (rd_addr),
        .rdata (top_row)
    );

    // ----------------------------------------
    // Left neighbour
    // ----------------------------------------

    // Right column of the most recent block
    always_ff @(posedge clk) begin
        if (blk_valid) begin
            left_reg <= right_col;
        end
    end

    // Snapshot at request time, so the next block write cannot disturb it
    always_ff @(posedge clk) begin
        if (pred_req) begin
            left_col <= left_reg;
        end
    end

    // ----------------------------------------
    // Request control and availability
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nb_valid   <= 1'b0;
            top_avail  <= 1'b0;
            left_avail <= 1'b0;
        end else begin
            nb_valid <= pred_req;
            if (pred_req) begin
                // No row above the first row, no column left of the first column
                top_avail  <= (req_y != '0);
                left_avail <= (req_x != '0);
            end
        end
    end

endmodule

// File: verilog/line_ram.sv
/*
 * Simple dual-port line RAM, one word per macroblock column.
 * Write port and registered read port share one clock; a read takes one cycle.
 */
`timescale 1ns/1ps

module line_ram #(
    parameter int  DEPTH  = 120,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [ADDR_W-1:0]           waddr,
    input  logic [intra_pkg::ROW_W-1:0] wdata,
    input  logic                        re,
    input  logic [ADDR_W-1:0]           raddr,
    output logic [intra_pkg::ROW_W-1:0] rdata
);

    logic [intra_pkg::ROW_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Output holds its word until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: verilog/intra_pkg.sv
/*
 * Sample and macroblock geometry for the luma intra neighbour store.
 * Modules refer to these constants as intra_pkg::NAME.
 */
package intra_pkg;

    // ----------------------------------------
    // Sample geometry
    // ----------------------------------------
    localparam int PIX_W   = 8;
    localparam int MB_SIZE = 16;

    // One row or column, then the whole 16x16 block
    localparam int ROW_W = PIX_W * MB_SIZE;
    localparam int BLK_W = ROW_W * MB_SIZE;

    // Mid-grey DC value when no neighbour exists
    localparam logic [PIX_W-1:0] DC_DEFAULT = PIX_W'(128);

    // Macroblock column and row positions
    localparam int POS_W = 8;

endpackage
